// File: Bender.yml
package:
  name: ntt_butterfly_2x2

sources:
  - src/ntt_pkg.sv
  - src/ntt_mod_mult.sv
  - src/ntt_butterfly.sv
  - src/ntt_operand_router.sv
  - src/ntt_ready_tracker.sv
  - src/ntt_butterfly_2x2.sv
  - target: test
    files:
      - bench/tb_ntt_butterfly_2x2.sv

// File: all.f
src/ntt_pkg.sv
src/ntt_mod_mult.sv
src/ntt_butterfly.sv
src/ntt_operand_router.sv
src/ntt_ready_tracker.sv
src/ntt_butterfly_2x2.sv
bench/tb_ntt_butterfly_2x2.sv

// File: bench/tb_ntt_butterfly_2x2.sv
// 2x2 NTT butterfly testbench

module tb_ntt_butterfly_2x2;

    localparam int unsigned Q = 8380417;

    logic               clk = 1'b0;
    logic               reset_n;
    logic               zeroize_i;
    logic               enable_i;
    ntt_pkg::mode_e     mode_i;
    logic               accumulate_i;
    ntt_pkg::uvw_2x2_t  uvw_i;
    ntt_pkg::pw_lanes_t pw_i;
    ntt_pkg::uv_2x2_t   uv_o;
    ntt_pkg::pw_out_t   pwo_o;
    logic               ready_o;

    logic [31:0]    lfsr_state = 32'd67;
    ntt_pkg::mode_e cur_mode;
    logic           cur_acc;
    int             cyc = 0;
    int             data_errors = 0;
    int             lat_errors = 0;
    int             other_errors = 0;

    // Scoreboard holds one entry per accepted set
    logic [91:0] exp_q[$];
    bit          is_uv_q[$];
    string       name_q[$];
    int          issue_q[$];

    ntt_butterfly_2x2 #(.Q(Q)) u_dut (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .enable_i     (enable_i),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .uvw_i        (uvw_i),
        .pw_i         (pw_i),
        .uv_o         (uv_o),
        .pwo_o        (pwo_o),
        .ready_o      (ready_o)
    );

    always #50 clk = ~clk;

    // --------------------
    // Random numbers
    // --------------------
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] r);
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
    endtask

    task automatic rand_coeffs(input int n, output logic [275:0] v);
        logic [31:0] r;
        v = '0;
        for (int i = 0; i < n; i++) begin
            rand_bits(ntt_pkg::COEFF_W, r);
            if (r >= Q) begin
                r = r - Q;
            end
            v = {v[275-ntt_pkg::COEFF_W:0], r[ntt_pkg::COEFF_W-1:0]};
        end
    endtask

    // --------------------
    // Reference model
    // --------------------
    function automatic ntt_pkg::coeff_t add_q(input longint unsigned a, input longint unsigned b);
        return ntt_pkg::coeff_t'((a + b) % Q);
    endfunction

    function automatic ntt_pkg::coeff_t sub_q(input longint unsigned a, input longint unsigned b);
        return ntt_pkg::coeff_t'((a + Q - b) % Q);
    endfunction

    function automatic ntt_pkg::coeff_t mul_q(input longint unsigned a, input longint unsigned b);
        return ntt_pkg::coeff_t'((a * b) % Q);
    endfunction

    function automatic ntt_pkg::bf_out_t ref_bf(input ntt_pkg::mode_e m,
            input ntt_pkg::coeff_t u, input ntt_pkg::coeff_t v, input ntt_pkg::coeff_t w);
        ntt_pkg::bf_out_t r;
        ntt_pkg::coeff_t  t;
        if (m == ntt_pkg::ct) begin
            t   = mul_q(w, v);
            r.u = add_q(u, t);
            r.v = sub_q(u, t);
        end else begin
            r.u = add_q(u, v);
            r.v = mul_q(sub_q(u, v), w);
        end
        return r;
    endfunction

    // Stage 1 on (u00, v00) and (u01, v01), then the cross-over into stage 2
    function automatic ntt_pkg::uv_2x2_t model_2x2(input ntt_pkg::mode_e m,
            input ntt_pkg::uvw_2x2_t s);
        ntt_pkg::bf_out_t a;
        ntt_pkg::bf_out_t b;
        ntt_pkg::bf_out_t c;
        ntt_pkg::bf_out_t d;
        a = ref_bf(m, s.u00, s.v00, s.w00);
        b = ref_bf(m, s.u01, s.v01, s.w01);
        c = ref_bf(m, a.u, b.u, s.w10);
        d = ref_bf(m, a.v, b.v, s.w11);
        return '{u20: c.u, v20: c.v, u21: d.u, v21: d.v};
    endfunction

    function automatic ntt_pkg::coeff_t ref_lane(input ntt_pkg::mode_e m, input logic acc,
            input ntt_pkg::bf_in_t l);
        case (m)
            ntt_pkg::pwm: return add_q(mul_q(l.u, l.v), acc ? l.w : ntt_pkg::coeff_t'(0));
            ntt_pkg::pwa: return add_q(l.u, l.v);
            default:      return sub_q(l.u, l.v);
        endcase
    endfunction

    // --------------------
    // Stimulus
    // --------------------
    task automatic set_mode(input ntt_pkg::mode_e m, input logic acc);
        @(posedge clk);
        mode_i       <= m;
        accumulate_i <= acc;
        cur_mode = m;
        cur_acc  = acc;
    endtask

    task automatic send_set(input string name, input int gap);
        logic [275:0]       v;
        ntt_pkg::uvw_2x2_t  s;
        ntt_pkg::pw_lanes_t p;
        rand_coeffs(8, v);
        s = v[183:0];
        rand_coeffs(12, v);
        p = v;
        @(posedge clk);
        uvw_i    <= s;
        pw_i     <= p;
        enable_i <= 1'b1;
        name_q.push_back(name);
        if (cur_mode inside {ntt_pkg::ct, ntt_pkg::gs}) begin
            exp_q.push_back(model_2x2(cur_mode, s));
            is_uv_q.push_back(1'b1);
        end else begin
            exp_q.push_back({ref_lane(cur_mode, cur_acc, p.lane0),
                             ref_lane(cur_mode, cur_acc, p.lane1),
                             ref_lane(cur_mode, cur_acc, p.lane2),
                             ref_lane(cur_mode, cur_acc, p.lane3)});
            is_uv_q.push_back(1'b0);
        end
        if (gap > 0) begin
            @(posedge clk);
            enable_i <= 1'b0;
            repeat (gap - 1) @(posedge clk);
        end
    endtask

    task automatic finish_run();
        $display("Errors: data %0d, latency %0d, other %0d",
                 data_errors, lat_errors, other_errors);
        if (data_errors + lat_errors + other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    // Bounded wait for every outstanding result
    task automatic drain(input string name);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 100) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("Timeout in %s: %0d results never arrived", name, exp_q.size());
            finish_run();
        end else begin
            repeat (2) @(posedge clk);
        end
    endtask

    // Random gaps of 1 to 4 cycles, or one enable per cycle for a burst
    task automatic run_sets(input string name, input int n, input bit burst);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            rand_bits(2, r);
            send_set(name, burst ? 0 : r + 1);
        end
        if (burst) begin
            @(posedge clk);
            enable_i <= 1'b0;
        end
        drain(name);
    endtask

    task automatic zeroize_in_flight();
        for (int i = 0; i < 5; i++) begin
            send_set("zeroize", 0);
        end
        @(posedge clk);
        enable_i  <= 1'b0;
        zeroize_i <= 1'b1;
        uvw_i     <= '0;
        pw_i      <= '0;
        exp_q.delete();
        is_uv_q.delete();
        name_q.delete();
        issue_q.delete();
        @(posedge clk);
        zeroize_i <= 1'b0;
        repeat (10) begin
            @(negedge clk);
            if (ready_o) begin
                other_errors++;
                $display("ready_o went high at cycle %0d after zeroize", cyc);
            end
            if ({uv_o, pwo_o} !== '0) begin
                data_errors++;
                $display("[ERROR] zeroize: expected %h, actual %h", 184'h0, {uv_o, pwo_o});
            end
        end
    endtask

    // --------------------
    // Monitor and scoreboard
    // --------------------
    task automatic check_result();
        logic [91:0] exp_v;
        logic [91:0] act_v;
        string       name;
        int          lat;
        int          issued;
        if (exp_q.size() == 0 || issue_q.size() == 0) begin
            other_errors++;
            $display("ready_o went high at cycle %0d with no set outstanding", cyc);
        end else begin
            exp_v  = exp_q.pop_front();
            name   = name_q.pop_front();
            issued = issue_q.pop_front();
            if (is_uv_q.pop_front()) begin
                act_v = uv_o;
                lat   = 2 * ntt_pkg::BF_LATENCY;
            end else begin
                act_v = pwo_o;
                lat   = ntt_pkg::BF_LATENCY;
            end
            if (act_v !== exp_v) begin
                data_errors++;
                $display("[ERROR] %s: expected %h, actual %h", name, exp_v, act_v);
            end
            if (cyc - issued != lat) begin
                lat_errors++;
                $display("[ERROR] %s latency: expected %0d, actual %0d", name, lat, cyc - issued);
            end
        end
    endtask

    always @(negedge clk) begin
        cyc = cyc + 1;
        if (reset_n && !zeroize_i && enable_i) begin
            issue_q.push_back(cyc);
        end
        if (ready_o) begin
            check_result();
        end
    end

    initial begin
        reset_n      = 1'b0;
        zeroize_i    = 1'b0;
        enable_i     = 1'b0;
        mode_i       = ntt_pkg::ct;
        accumulate_i = 1'b0;
        uvw_i        = '0;
        pw_i         = '0;
        cur_mode     = ntt_pkg::ct;
        cur_acc      = 1'b0;
        repeat (10) @(posedge clk);
        reset_n <= 1'b1;

        set_mode(ntt_pkg::ct, 1'b0);
        run_sets("ct_random", 40, 1'b0);
        set_mode(ntt_pkg::gs, 1'b0);
        run_sets("gs_random", 40, 1'b0);
        set_mode(ntt_pkg::pwm, 1'b0);
        run_sets("pwm_acc_off", 40, 1'b0);
        set_mode(ntt_pkg::pwm, 1'b1);
        run_sets("pwm_acc_on", 40, 1'b0);
        set_mode(ntt_pkg::pwa, 1'b0);
        run_sets("pwa_random", 30, 1'b0);
        set_mode(ntt_pkg::pws, 1'b0);
        run_sets("pws_random", 30, 1'b0);

        // Back-to-back enables
        set_mode(ntt_pkg::ct, 1'b0);
        run_sets("ct_burst", 16, 1'b1);
        set_mode(ntt_pkg::pwm, 1'b1);
        run_sets("pwm_burst", 16, 1'b1);

        set_mode(ntt_pkg::ct, 1'b0);
        zeroize_in_flight();

        finish_run();
    end

endmodule

// File: src/ntt_butterfly.sv
// Single CT/GS/pointwise butterfly unit

module ntt_butterfly #(
    parameter int unsigned Q = 8380417
) (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             zeroize_i,
    input  ntt_pkg::mode_e   mode_i,
    input  logic             accumulate_i,
    input  ntt_pkg::bf_in_t  op_i,
    output ntt_pkg::bf_out_t res_o
);

    localparam int W = ntt_pkg::COEFF_W;
    localparam logic [W:0] Q_X = (W+1)'(Q);

    // Term that bypasses the multiplier, tagged with its mode
    typedef struct packed {
        ntt_pkg::coeff_t side;
        ntt_pkg::mode_e  mode;
    } side_t;

    function automatic ntt_pkg::coeff_t add_mod(input ntt_pkg::coeff_t a,
                                                input ntt_pkg::coeff_t b);
        logic [W:0] s;
        s = a + b;
        if (s >= Q_X) begin
            s = s - Q_X;
        end
        return s[W-1:0];
    endfunction

    function automatic ntt_pkg::coeff_t sub_mod(input ntt_pkg::coeff_t a,
                                                input ntt_pkg::coeff_t b);
        logic [W:0] d;
        d = {1'b0, a} - {1'b0, b};
        if (a < b) begin
            d = d + Q_X;
        end
        return d[W-1:0];
    endfunction

    ntt_pkg::bf_in_t s1_op;
    ntt_pkg::coeff_t s1_sum;
    ntt_pkg::coeff_t s1_diff;
    ntt_pkg::mode_e  s1_mode;
    logic            s1_acc;

    ntt_pkg::coeff_t mult_a;
    ntt_pkg::coeff_t mult_b;
    ntt_pkg::coeff_t mult_p;
    side_t           side_in;
    side_t [ntt_pkg::MULT_LATENCY-1:0] side_sr;
    side_t           side_out;

    // --------------------
    // Input stage
    // --------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_op   <= '0;
            s1_sum  <= '0;
            s1_diff <= '0;
            s1_mode <= ntt_pkg::ct;
            s1_acc  <= 1'b0;
        end else if (zeroize_i) begin
            s1_op   <= '0;
            s1_sum  <= '0;
            s1_diff <= '0;
            s1_mode <= ntt_pkg::ct;
            s1_acc  <= 1'b0;
        end else begin
            s1_op   <= op_i;
            s1_sum  <= add_mod(op_i.u, op_i.v);
            s1_diff <= sub_mod(op_i.u, op_i.v);
            s1_mode <= mode_i;
            s1_acc  <= accumulate_i;
        end
    end

    // Multiplier operands and bypass term per mode
    always_comb begin
        mult_a       = '0;
        mult_b       = '0;
        side_in.side = '0;
        side_in.mode = s1_mode;
        case (s1_mode)
            ntt_pkg::ct: begin
                mult_a       = s1_op.v;
                mult_b       = s1_op.w;
                side_in.side = s1_op.u;
            end
            ntt_pkg::gs: begin
                mult_a       = s1_diff;
                mult_b       = s1_op.w;
                side_in.side = s1_sum;
            end
            ntt_pkg::pwm: begin
                mult_a       = s1_op.u;
                mult_b       = s1_op.v;
                side_in.side = s1_acc ? s1_op.w : '0;
            end
            ntt_pkg::pwa: side_in.side = s1_sum;
            ntt_pkg::pws: side_in.side = s1_diff;
            default: ;
        endcase
    end

    ntt_mod_mult #(
        .Q(Q)
    ) u_mult (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .a_i       (mult_a),
        .b_i       (mult_b),
        .p_o       (mult_p)
    );

    // --------------------
    // Bypass delay
    // --------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            side_sr <= '0;
        end else if (zeroize_i) begin
            side_sr <= '0;
        end else begin
            side_sr <= {side_in, side_sr[ntt_pkg::MULT_LATENCY-1:1]};
        end
    end

    assign side_out = side_sr[0];

    // Final add/sub after the product lands
    always_comb begin
        res_o.u = side_out.side;
        res_o.v = '0;
        case (side_out.mode)
            ntt_pkg::ct: begin
                res_o.u = add_mod(side_out.side, mult_p);
                res_o.v = sub_mod(side_out.side, mult_p);
            end
            ntt_pkg::gs:  res_o.v = mult_p;
            ntt_pkg::pwm: res_o.u = add_mod(side_out.side, mult_p);
            default: ;
        endcase
    end

endmodule

// File: src/ntt_butterfly_2x2.sv
// 2x2 NTT butterfly block

module ntt_butterfly_2x2 #(
    parameter int unsigned Q = 8380417
) (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               zeroize_i,
    input  logic               enable_i,
    input  ntt_pkg::mode_e     mode_i,
    input  logic               accumulate_i,
    input  ntt_pkg::uvw_2x2_t  uvw_i,
    input  ntt_pkg::pw_lanes_t pw_i,
    output ntt_pkg::uv_2x2_t   uv_o,
    output ntt_pkg::pw_out_t   pwo_o,
    output logic               ready_o
);

    ntt_pkg::bf_in_t  op00;
    ntt_pkg::bf_in_t  op01;
    ntt_pkg::bf_in_t  op10;
    ntt_pkg::bf_in_t  op11;
    ntt_pkg::bf_out_t res00;
    ntt_pkg::bf_out_t res01;
    ntt_pkg::bf_out_t res10;
    ntt_pkg::bf_out_t res11;

    ntt_operand_router u_router (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize_i      (zeroize_i),
        .mode_i         (mode_i),
        .uvw_i          (uvw_i),
        .pw_i           (pw_i),
        .stage1_u_res_i (res00),
        .stage1_v_res_i (res01),
        .op00_o         (op00),
        .op01_o         (op01),
        .op10_o         (op10),
        .op11_o         (op11)
    );

    // --------------------
    // Butterfly units
    // --------------------
    ntt_butterfly #(.Q(Q)) u_bf00 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i), .mode_i(mode_i),
        .accumulate_i(accumulate_i), .op_i(op00), .res_o(res00)
    );

    ntt_butterfly #(.Q(Q)) u_bf01 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i), .mode_i(mode_i),
        .accumulate_i(accumulate_i), .op_i(op01), .res_o(res01)
    );

    ntt_butterfly #(.Q(Q)) u_bf10 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i), .mode_i(mode_i),
        .accumulate_i(accumulate_i), .op_i(op10), .res_o(res10)
    );

    ntt_butterfly #(.Q(Q)) u_bf11 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i), .mode_i(mode_i),
        .accumulate_i(accumulate_i), .op_i(op11), .res_o(res11)
    );

    ntt_ready_tracker u_ready (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .enable_i  (enable_i),
        .mode_i    (mode_i),
        .ready_o   (ready_o)
    );

    // Stage-2 results
    assign uv_o = '{u20: res10.u, v20: res10.v, u21: res11.u, v21: res11.v};

    // Pointwise results in lane order 00 to 11
    assign pwo_o = '{uv0: res00.u, uv1: res01.u, uv2: res10.u, uv3: res11.u};

endmodule

// File: src/ntt_mod_mult.sv
// Pipelined Barrett modular multiplier

module ntt_mod_mult #(
    parameter int unsigned Q = 8380417
) (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            zeroize_i,
    input  ntt_pkg::coeff_t a_i,
    input  ntt_pkg::coeff_t b_i,
    output ntt_pkg::coeff_t p_o
);

    localparam int W = ntt_pkg::COEFF_W;

    // floor(2^(2W) / Q)
    localparam logic [2*W:0] BARRETT_MU = {1'b1, {(2*W){1'b0}}} / Q;
    localparam ntt_pkg::coeff_t Q_C = ntt_pkg::coeff_t'(Q);
    localparam logic [W+1:0] Q_X1 = (W+2)'(Q);
    localparam logic [W+1:0] Q_X2 = (W+2)'(2 * Q);

    logic [2*W-1:0] prod_q;
    logic [2*W-1:0] prod_d;
    logic [W:0]     quot_q;
    ntt_pkg::coeff_t res_q;

    logic [4*W:0]   mu_prod;
    logic [2*W-1:0] quot_mult;
    logic [2*W-1:0] rem_full;
    logic [W+1:0]   rem;
    logic [W+1:0]   red;

    assign mu_prod   = prod_q * BARRETT_MU;
    assign quot_mult = quot_q * Q_C;
    assign rem_full  = prod_d - quot_mult;

    // Estimate is at most two short, so the remainder stays below 3Q
    assign rem = rem_full[W+1:0];

    always_comb begin
        if (rem >= Q_X2) begin
            red = rem - Q_X2;
        end else if (rem >= Q_X1) begin
            red = rem - Q_X1;
        end else begin
            red = rem;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_q <= '0;
            prod_d <= '0;
            quot_q <= '0;
            res_q  <= '0;
        end else if (zeroize_i) begin
            prod_q <= '0;
            prod_d <= '0;
            quot_q <= '0;
            res_q  <= '0;
        end else begin
            prod_q <= a_i * b_i;
            prod_d <= prod_q;
            quot_q <= mu_prod[2*W +: W+1];
            res_q  <= red[W-1:0];
        end
    end

    assign p_o = res_q;

    a_operands_in_range: assert property (
        @(posedge clk) disable iff (!reset_n || zeroize_i)
        (a_i < Q) && (b_i < Q)
    );

endmodule

// File: src/ntt_operand_router.sv
// Butterfly operand routing and twiddle delay

module ntt_operand_router (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize_i,
    input  ntt_pkg::mode_e      mode_i,
    input  ntt_pkg::uvw_2x2_t   uvw_i,
    input  ntt_pkg::pw_lanes_t  pw_i,
    input  ntt_pkg::bf_out_t    stage1_u_res_i,
    input  ntt_pkg::bf_out_t    stage1_v_res_i,
    output ntt_pkg::bf_in_t     op00_o,
    output ntt_pkg::bf_in_t     op01_o,
    output ntt_pkg::bf_in_t     op10_o,
    output ntt_pkg::bf_in_t     op11_o
);

    ntt_pkg::coeff_t [ntt_pkg::BF_LATENCY-1:0] w10_sr;
    ntt_pkg::coeff_t [ntt_pkg::BF_LATENCY-1:0] w11_sr;
    logic pw_mode;

    // --------------------
    // Stage-2 twiddle delay
    // --------------------
    // Holds w10/w11 until the matching stage-1 results appear
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            w10_sr <= '0;
            w11_sr <= '0;
        end else if (zeroize_i) begin
            w10_sr <= '0;
            w11_sr <= '0;
        end else begin
            w10_sr <= {uvw_i.w10, w10_sr[ntt_pkg::BF_LATENCY-1:1]};
            w11_sr <= {uvw_i.w11, w11_sr[ntt_pkg::BF_LATENCY-1:1]};
        end
    end

    assign pw_mode = mode_i inside {ntt_pkg::pwm, ntt_pkg::pwa, ntt_pkg::pws};

    always_comb begin
        if (pw_mode) begin
            // Four independent lanes
            op00_o = pw_i.lane0;
            op01_o = pw_i.lane1;
            op10_o = pw_i.lane2;
            op11_o = pw_i.lane3;
        end else begin
            op00_o = '{u: uvw_i.u00, v: uvw_i.v00, w: uvw_i.w00};
            op01_o = '{u: uvw_i.u01, v: uvw_i.v01, w: uvw_i.w01};
            // Cross-over of stage-1 results
            op10_o = '{u: stage1_u_res_i.u, v: stage1_v_res_i.u, w: w10_sr[0]};
            op11_o = '{u: stage1_u_res_i.v, v: stage1_v_res_i.v, w: w11_sr[0]};
        end
    end

endmodule

// File: src/ntt_pkg.sv
// NTT butterfly shared types

package ntt_pkg;

    // --------------------
    // Widths and latencies
    // --------------------
    localparam int COEFF_W = 23;

    // Product register, Barrett quotient, corrected remainder
    localparam int MULT_LATENCY = 3;

    // Input register stage followed by the multiplier
    localparam int BF_LATENCY = MULT_LATENCY + 1;

    typedef logic [COEFF_W-1:0] coeff_t;

    // Operation select
    typedef enum logic [2:0] {
        ct  = 3'd0,
        gs  = 3'd1,
        pwm = 3'd2,
        pwa = 3'd3,
        pws = 3'd4
    } mode_e;

    // --------------------
    // Single unit operands and results
    // --------------------
    typedef struct packed {
        coeff_t u;
        coeff_t v;
        coeff_t w;
    } bf_in_t;

    typedef struct packed {
        coeff_t u;
        coeff_t v;
    } bf_out_t;

    // --------------------
    // 2x2 block operands and results
    // --------------------
    // Stage-2 twiddles w10 and w11 arrive with the stage-1 operands
    typedef struct packed {
        coeff_t u00;
        coeff_t v00;
        coeff_t w00;
        coeff_t u01;
        coeff_t v01;
        coeff_t w01;
        coeff_t w10;
        coeff_t w11;
    } uvw_2x2_t;

    typedef struct packed {
        bf_in_t lane0;
        bf_in_t lane1;
        bf_in_t lane2;
        bf_in_t lane3;
    } pw_lanes_t;

    typedef struct packed {
        coeff_t u20;
        coeff_t v20;
        coeff_t u21;
        coeff_t v21;
    } uv_2x2_t;

    typedef struct packed {
        coeff_t uv0;
        coeff_t uv1;
        coeff_t uv2;
        coeff_t uv3;
    } pw_out_t;

endpackage

// File: src/ntt_ready_tracker.sv
// Result ready strobe generation

module ntt_ready_tracker (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           zeroize_i,
    input  logic           enable_i,
    input  ntt_pkg::mode_e mode_i,
    output logic           ready_o
);

    localparam int BF_LAT = ntt_pkg::BF_LATENCY;
    localparam int DEPTH  = 2 * BF_LAT;

    logic [DEPTH-1:0] ready_sr;
    logic             two_stage;

    // ct and gs pass through both butterfly stages
    assign two_stage = (mode_i == ntt_pkg::ct) || (mode_i == ntt_pkg::gs);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ready_sr <= '0;
        end else if (zeroize_i) begin
            ready_sr <= '0;
        end else if (two_stage) begin
            ready_sr <= {enable_i, ready_sr[DEPTH-1:1]};
        end else begin
            // Pointwise sets enter halfway down
            ready_sr <= {{(DEPTH-BF_LAT){1'b0}}, enable_i, ready_sr[BF_LAT-1:1]};
        end
    end

    assign ready_o = ready_sr[0];

    // Mode may only change once every accepted set has left the pipe
    a_mode_stable_in_flight: assert property (
        @(posedge clk) disable iff (!reset_n || zeroize_i)
        (enable_i || (|ready_sr[DEPTH-1:1])) |=> $stable(mode_i)
    );

endmodule
